// File: verilog/collector_defines.svh
`ifndef COLLECTOR_DEFINES_SVH
`define COLLECTOR_DEFINES_SVH

// ------------------------------
// request side
// ------------------------------

// requester ports feeding the arbiter
`define NUM_REQUESTERS 5

// data word carried by each requester
`define PAYLOAD_WIDTH 16

// ------------------------------
// queue
// ------------------------------

// entries held between arbiter and consumer
// must stay a power of two so the pointers wrap on their own
`define FIFO_DEPTH 8

`endif

// File: verilog/collectorPkg.sv
`include "collector_defines.svh"

package collectorPkg;

	// enough bits to name any requester
	localparam int IndexWidth = (`NUM_REQUESTERS > 1) ? $clog2(`NUM_REQUESTERS) : 1;

	// ------------------------------
	// request side types
	// ------------------------------

	typedef logic [IndexWidth-1:0] requesterIndex;      // rotation value, winner, tag
	typedef logic [`PAYLOAD_WIDTH-1:0] payloadWord;     // one requester's data
	typedef logic [`NUM_REQUESTERS-1:0] requestVector;  // one flag per requester

	// all requester words side by side, slot k is requester k
	typedef payloadWord [`NUM_REQUESTERS-1:0] payloadArray;

	// ------------------------------
	// queued word
	// ------------------------------

	// winner tag on top, payload below
	typedef struct packed
	{
		requesterIndex source;  // who sent it
		payloadWord    data;    // what was sent
	} fifoEntry;

endpackage

// File: verilog/roundRobinGrant.sv
`include "collector_defines.svh"

module roundRobinGrant
(
	input  logic                      Clock,
	input  logic                      Reset,
	input  collectorPkg::requestVector request,
	input  collectorPkg::payloadArray  payload,
	input  logic                      full,         // queue cannot take a word
	output collectorPkg::requestVector grant,        // one-hot or zero
	output logic                      writeEnable,
	output collectorPkg::fifoEntry     writeEntry
);
	import collectorPkg::*;

	localparam int NumReq = `NUM_REQUESTERS;

	requesterIndex rotation;      // search start, free running
	requestVector  priorityMask;  // ones at and above rotation
	requestVector  upperRequest;  // requests inside the mask
	requestVector  upperFirst;    // lowest masked request
	requestVector  lowerFirst;    // lowest request overall
	requestVector  winnerOneHot;  // before the full gate
	logic [NumReq:0] upperClear;  // no masked request below this slot
	logic [NumReq:0] lowerClear;  // no request at all below this slot
	logic          anyRequest;
	requesterIndex winnerIndex;
	payloadWord    winnerPayload;

	// ------------------------------
	// rotation register
	// ------------------------------

	// steps every cycle, requests or not
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
			rotation <= '0;
		else if (rotation == requesterIndex'(NumReq - 1))
			rotation <= '0;                   // wrap back to requester 0
		else
			rotation <= rotation + 1'b1;
	end

	// ------------------------------
	// priority search
	// ------------------------------

	// two ripple chains side by side
	// upper one only sees requesters at or past rotation
	// lower one sees everyone and covers the wrap
	assign upperClear[0] = 1'b1;
	assign lowerClear[0] = 1'b1;

	for (genvar j = 0; j < NumReq; j++)
	begin : searchStage
		assign priorityMask[j] = (rotation <= requesterIndex'(j));
		assign upperRequest[j] = request[j] & priorityMask[j];

		assign upperFirst[j]   = upperRequest[j] & upperClear[j];
		assign upperClear[j+1] = upperClear[j] & ~upperRequest[j];

		assign lowerFirst[j]   = request[j] & lowerClear[j];
		assign lowerClear[j+1] = lowerClear[j] & ~request[j];
	end

	// nothing at or past rotation, so wrap to the lowest request
	assign winnerOneHot = upperClear[NumReq] ? lowerFirst : upperFirst;
	assign anyRequest   = ~lowerClear[NumReq];

	// full queue holds every requester off
	assign grant       = winnerOneHot & {NumReq{~full}};
	assign writeEnable = anyRequest & ~full;

	// ------------------------------
	// winner encode and payload mux
	// ------------------------------

	always_comb
	begin
		winnerIndex   = '0;
		winnerPayload = '0;
		for (int k = 0; k < NumReq; k++)
		begin
			if (winnerOneHot[k])
			begin
				winnerIndex   = requesterIndex'(k);
				winnerPayload = payload[k];   // at most one hit
			end
		end
	end

	// tag the word with its source
	assign writeEntry = '{source: winnerIndex, data: winnerPayload};

endmodule

// File: verilog/entryFifo.sv
`include "collector_defines.svh"

module entryFifo
#(
	parameter int Depth = `FIFO_DEPTH   // power of two
)
(
	input  logic                  Clock,
	input  logic                  Reset,
	input  logic                  writeEnable,
	input  collectorPkg::fifoEntry writeEntry,
	input  logic                  readEnable,
	output collectorPkg::fifoEntry readEntry,    // head, falls through
	output logic                  full,
	output logic                  empty
);
	import collectorPkg::*;

	localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;

	fifoEntry storage [Depth];

	// top bit of each pointer is the lap marker
	logic [AddrWidth:0]   writePtr;
	logic [AddrWidth:0]   readPtr;
	logic [AddrWidth-1:0] writeAddr;
	logic [AddrWidth-1:0] readAddr;
	logic                 writeWrap;
	logic                 readWrap;
	logic                 writeAccept;
	logic                 readAccept;

	// ------------------------------
	// pointer fields
	// ------------------------------

	assign writeAddr = writePtr[AddrWidth-1:0];
	assign readAddr  = readPtr[AddrWidth-1:0];
	assign writeWrap = writePtr[AddrWidth];
	assign readWrap  = readPtr[AddrWidth];

	// same slot, same lap means nothing stored
	// same slot, other lap means the writer caught up
	assign empty = (writeAddr == readAddr) & (writeWrap == readWrap);
	assign full  = (writeAddr == readAddr) & (writeWrap != readWrap);

	assign writeAccept = writeEnable & ~full;
	assign readAccept  = readEnable & ~empty;   // read on empty is dropped

	// ------------------------------
	// pointers
	// ------------------------------

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
			writePtr <= '0;
		else if (writeAccept)
			writePtr <= writePtr + 1'b1;    // carry flips the lap bit
	end

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
			readPtr <= '0;
		else if (readAccept)
			readPtr <= readPtr + 1'b1;
	end

	// ------------------------------
	// storage
	// ------------------------------

	always_ff @(posedge Clock)
	begin
		if (writeAccept)
			storage[writeAddr] <= writeEntry;
	end

	// head word straight from the array
	// a write shows up here one edge later
	assign readEntry = storage[readAddr];

endmodule

// File: verilog/requestCollector.sv
`include "collector_defines.svh"

module requestCollector
(
	input  logic                      Clock,
	input  logic                      Reset,

	// requester side
	input  collectorPkg::requestVector request,
	input  collectorPkg::payloadArray  payload,
	output collectorPkg::requestVector grant,

	// consumer side
	output logic                      outValid,
	input  logic                      outReady,
	output collectorPkg::fifoEntry     outEntry
);
	import collectorPkg::*;

	logic     writeEnable;   // arbiter has a winner this cycle
	fifoEntry writeEntry;    // tagged winner word
	logic     fifoFull;      // back to the arbiter
	logic     fifoEmpty;

	// ------------------------------
	// arbiter
	// ------------------------------

	roundRobinGrant grantInst
	(
		.Clock       (Clock),
		.Reset       (Reset),
		.request     (request),
		.payload     (payload),
		.full        (fifoFull),
		.grant       (grant),
		.writeEnable (writeEnable),
		.writeEntry  (writeEntry)
	);

	// ------------------------------
	// queue
	// ------------------------------

	entryFifo
	#(
		.Depth (`FIFO_DEPTH)
	)
	fifoInst
	(
		.Clock       (Clock),
		.Reset       (Reset),
		.writeEnable (writeEnable),
		.writeEntry  (writeEntry),
		.readEnable  (outReady),     // pop when the consumer takes it
		.readEntry   (outEntry),
		.full        (fifoFull),
		.empty       (fifoEmpty)
	);

	assign outValid = ~fifoEmpty;   // head is valid whenever something is queued

endmodule

// File: tb/requestCollectorTb.sv
`include "collector_defines.svh"

module requestCollectorTb;
	timeunit 1ns;
	timeprecision 1ps;

	import collectorPkg::*;

	localparam int NumReq           = `NUM_REQUESTERS;
	localparam int FifoDepth        = `FIFO_DEPTH;
	localparam int ClockPeriod      = 20;
	localparam int ResetCycles      = 10;
	localparam int IdleCycles       = 5;
	localparam int SingleCount      = 12;   // words in the single stream
	localparam int ContentionCycles = 40;
	localparam int BackCycles       = 30;
	localparam int RandomCycles     = 200;
	localparam int DrainBudget      = FifoDepth + 2 * NumReq + 10;

	// cycle budget of every test, summed for the watchdog
	localparam int TotalCycles = ResetCycles + IdleCycles
		+ 3 * SingleCount + DrainBudget
		+ ContentionCycles + DrainBudget
		+ BackCycles + DrainBudget
		+ RandomCycles + DrainBudget;
	localparam int WatchdogNs = TotalCycles * ClockPeriod + 500;

	logic         Clock;
	logic         Reset;
	requestVector request;
	payloadArray  payload;
	requestVector grant;
	logic         outValid;
	logic         outReady;
	fifoEntry     outEntry;

	fifoEntry     modelQueue [$];   // what the FIFO should hold
	requestVector acceptedMask;     // taken on the coming edge
	int           edgeCount;        // edges since reset fell
	int           acceptCount;      // request/grant handshakes seen
	logic         heldValid;        // head was stalled last cycle
	fifoEntry     heldEntry;
	integer       seed;
	string        testName;
	int           testChecks;
	int           testFails;
	int           totalChecks;
	int           totalFails;
	int           testsRun;

	requestCollector requestCollector_inst
	(
		.Clock    (Clock),
		.Reset    (Reset),
		.request  (request),
		.payload  (payload),
		.grant    (grant),
		.outValid (outValid),
		.outReady (outReady),
		.outEntry (outEntry)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// rotation value of the arbiter is edgeCount mod NumReq
	always @(posedge Clock)
	begin
		if (Reset)
			edgeCount <= 0;
		else
			edgeCount <= edgeCount + 1;
	end

	// first request at or after the start index, wrapping upward
	function automatic requestVector pickWinner(requestVector req, int start, logic isFull);
		requestVector result;
		int idx;
		result = '0;
		if (!isFull)
		begin
			for (int step = 0; step < NumReq; step++)
			begin
				idx = (start + step) % NumReq;
				if (req[idx] && result == '0)
					result[idx] = 1'b1;
			end
		end
		return result;
	endfunction

	// ------------------------------
	// model and checks at mid-cycle
	// ------------------------------

	always @(negedge Clock)
	begin
		requestVector expGrant;
		fifoEntry     expHead;
		if (!Reset)
		begin
			expGrant = pickWinner(request, edgeCount % NumReq, modelQueue.size() >= FifoDepth);
			testChecks += 3;
			assert (grant === expGrant)
			else
			begin
				$display("FAIL %s grant expected %b actual %b", testName, expGrant, grant);
				testFails++;
			end
			assert ($onehot0(grant) && (grant & ~request) == '0)
			else
			begin
				$display("%s: grant %b is not one-hot or goes to an idle requester",
					testName, grant);
				testFails++;
			end
			assert (outValid === (modelQueue.size() != 0))
			else
			begin
				$display("FAIL %s outValid expected %b actual %b", testName,
					modelQueue.size() != 0, outValid);
				testFails++;
			end
			if (heldValid)   // stalled head must not move
			begin
				testChecks++;
				assert (outEntry === heldEntry)
				else
				begin
					$display("FAIL %s held entry expected %h actual %h", testName,
						heldEntry, outEntry);
					testFails++;
				end
			end
			if (outValid && outReady)
			begin
				testChecks++;
				assert (modelQueue.size() != 0)
				else
				begin
					$display("%s: DUT delivered an entry the model never accepted", testName);
					testFails++;
				end
				if (modelQueue.size() != 0)
				begin
					expHead = modelQueue.pop_front();
					testChecks++;
					assert (outEntry === expHead)
					else
					begin
						$display("FAIL %s entry expected %h actual %h", testName,
							expHead, outEntry);
						testFails++;
					end
				end
			end
			for (int i = 0; i < NumReq; i++)
			begin
				if (expGrant[i])
					modelQueue.push_back(fifoEntry'{source: requesterIndex'(i), data: payload[i]});
			end
			acceptedMask = grant & request;   // stimulus drops these next edge
			acceptCount += $countones(acceptedMask);
			heldValid    = outValid & ~outReady;
			heldEntry    = outEntry;
		end
		else
		begin
			acceptedMask = '0;
			heldValid    = 1'b0;
		end
	end

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	// drop granted words and raise new ones from offerMask on one edge
	task automatic offerCycle(input requestVector offerMask, input logic readyValue,
		output int newOffers, output requestVector driven);
		payloadArray nextPayload;
		@(posedge Clock);
		driven      = request & ~acceptedMask;
		nextPayload = payload;
		newOffers   = 0;
		for (int i = 0; i < NumReq; i++)
		begin
			if (!driven[i] && offerMask[i])
			begin
				driven[i]      = 1'b1;
				nextPayload[i] = payloadWord'($random(seed));
				newOffers++;
			end
		end
		request  <= driven;
		payload  <= nextPayload;
		outReady <= readyValue;
	endtask

	// no new offers, consumer ready, until nothing is left anywhere
	task automatic drainAll();
		int           newOffers;
		int           cycles;
		requestVector driven;
		cycles = 0;
		do
		begin
			offerCycle('0, 1'b1, newOffers, driven);
			cycles++;
		end
		while ((driven != '0 || modelQueue.size() != 0) && cycles < DrainBudget);
		testChecks++;
		assert (modelQueue.size() == 0 && driven == '0)
		else
		begin
			$display("%s: drain ended with %0d entries never out and requests %b waiting",
				testName, modelQueue.size(), driven);
			testFails++;
		end
	endtask

	task automatic finishTest();
		$display("test %-12s done  %0d checks  %0d failed", testName, testChecks, testFails);
		totalChecks += testChecks;
		totalFails  += testFails;
		testsRun++;
		testChecks = 0;
		testFails  = 0;
	endtask

	// ------------------------------
	// tests
	// ------------------------------

	task automatic checkResetState();
		int           newOffers;
		requestVector driven;
		testName = "reset";
		repeat (ResetCycles)
		begin
			@(negedge Clock);
			testChecks += 2;
			assert (outValid === 1'b0)
			else
			begin
				$display("FAIL %s outValid expected 0 actual %b", testName, outValid);
				testFails++;
			end
			assert (grant === '0)
			else
			begin
				$display("FAIL %s grant expected %b actual %b", testName, requestVector'(0), grant);
				testFails++;
			end
		end
		@(posedge Clock);
		Reset <= 1'b0;
		repeat (IdleCycles)
			offerCycle('0, 1'b0, newOffers, driven);   // monitor sees idle
		finishTest();
	endtask

	task automatic streamSingleRequester();
		int           pick;
		int           offered;
		int           startCount;
		int           newOffers;
		requestVector driven;
		requestVector single;
		testName   = "single";
		pick       = $unsigned($random(seed)) % NumReq;
		single     = '0;
		single[pick] = 1'b1;
		offered    = 0;
		startCount = acceptCount;
		while (acceptCount - startCount < SingleCount)
		begin
			offerCycle((offered < SingleCount) ? single : '0, 1'b1, newOffers, driven);
			offered += newOffers;
		end
		drainAll();
		finishTest();
	endtask

	task automatic contendAll();
		int           newOffers;
		requestVector driven;
		testName = "contention";
		repeat (ContentionCycles)
			offerCycle('1, 1'b1, newOffers, driven);
		drainAll();
		finishTest();
	endtask

	task automatic holdBackConsumer();
		int           startCount;
		int           newOffers;
		requestVector driven;
		testName   = "backpressure";
		startCount = acceptCount;
		repeat (BackCycles)
			offerCycle('1, 1'b0, newOffers, driven);   // consumer stalled
		testChecks++;
		assert (acceptCount - startCount == FifoDepth)
		else
		begin
			$display("FAIL %s accepted expected %0d actual %0d", testName, FifoDepth,
				acceptCount - startCount);
			testFails++;
		end
		drainAll();
		finishTest();
	endtask

	task automatic mixRandomTraffic();
		int           newOffers;
		requestVector driven;
		requestVector offerMask;
		logic [31:0]  randomBits;
		logic         readyBit;
		testName = "random";
		repeat (RandomCycles)
		begin
			for (int i = 0; i < NumReq; i++)
			begin
				randomBits   = $random(seed);
				offerMask[i] = (randomBits[1:0] == 2'b00);   // about one in four
			end
			randomBits = $random(seed);
			readyBit   = randomBits[0];
			offerCycle(offerMask, readyBit, newOffers, driven);
		end
		drainAll();
		finishTest();
	endtask

	// ------------------------------
	// sequence and watchdog
	// ------------------------------

	initial
	begin
		seed         = 32'h9c62;
		Clock        = 1'b0;
		Reset        = 1'b1;
		request      = '0;
		payload      = '0;
		outReady     = 1'b0;
		acceptedMask = '0;
		acceptCount  = 0;
		heldValid    = 1'b0;
		testChecks   = 0;
		testFails    = 0;
		totalChecks  = 0;
		totalFails   = 0;
		testsRun     = 0;
		checkResetState();
		streamSingleRequester();
		contendAll();
		holdBackConsumer();
		mixRandomTraffic();
		$display("summary  %0d tests  %0d checks  %0d failed", testsRun, totalChecks, totalFails);
		if (totalFails == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		#(WatchdogNs);
		$display("watchdog expired after %0d ns, a handshake never completed", WatchdogNs);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: files.f
+incdir+verilog
verilog/collectorPkg.sv
verilog/roundRobinGrant.sv
verilog/entryFifo.sv
verilog/requestCollector.sv
tb/requestCollectorTb.sv

// File: run.sh
#!/bin/sh
# build the collector with its testbench, run it, then grade the log

rm -f sim.log && \
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module requestCollectorTb -Mdir obj_dir -f files.f && \
./obj_dir/VrequestCollectorTb > sim.log || { echo "build or run did not complete"; exit 1; }

cat sim.log
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
